//--- common/tcp_pkg.sv
package tcp_pkg;

	// ------------------------------------------------------------
	// Header field types
	// ------------------------------------------------------------
	typedef logic [31:0] seq_num_t;
	typedef logic [15:0] port_t;
	typedef logic [5:0]  flags_t;
	typedef logic [15:0] data_len_t;
	typedef logic [15:0] window_t;
	typedef logic [3:0]  head_len_t;

	// Flag bits, from msb: URG ACK PSH RST SYN FIN
	localparam int FLAG_FIN = 0;
	localparam int FLAG_SYN = 1;
	localparam int FLAG_RST = 2;
	localparam int FLAG_ACK = 4;

	// ------------------------------------------------------------
	// Flag sets for transmitted segments
	// ------------------------------------------------------------
	localparam flags_t FLAGS_SYN_ACK = 6'h12;
	localparam flags_t FLAGS_ACK     = 6'h10;
	localparam flags_t FLAGS_PSH_ACK = 6'h18;
	localparam flags_t FLAGS_FIN_ACK = 6'h11;
	localparam flags_t FLAGS_RST_ACK = 6'h14;
	localparam flags_t FLAGS_RST     = 6'h04;

	// Server port, 63256 decimal
	localparam port_t LOCAL_PORT = 16'hF718;

	// ISN is not randomized
	localparam seq_num_t INIT_SEQ_NUM = 32'h0000_0000;

	// Five words, no options
	localparam head_len_t BASE_HEAD_LEN = 4'd5;

endpackage

//--- common/tcp_ctrl_pkg.sv
package tcp_ctrl_pkg;

	// Passive-open subset of the TCP state diagram
	typedef enum logic [2:0] {
		LISTEN,
		SYN_RCVD,
		ESTABLISHED,
		CLOSE_WAIT,
		LAST_ACK,
		CLOSED
	} conn_state_t;

	// Counts up to the limit itself, hence five bits
	typedef logic [4:0] pkt_cnt_t;

	// Window in bytes as computed from the peer ack
	typedef logic [31:0] tx_window_t;

	// Data segments in flight before an ACK is required
	localparam pkt_cnt_t MAX_UNACKED_PKTS = 5'd16;

	// Bytes of peer window needed to start a new segment
	localparam tx_window_t MIN_TX_WINDOW = 32'd25000;

endpackage

//--- design/tcp_rx_intake.sv
module tcp_rx_intake
	import tcp_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   tcp_op_rcv_i,
	input  flags_t tcp_flags_i,
	input  logic   ctrl_cmd_start_i,
	input  logic   tcp_wdat_start_i,
	input  logic   trnsmt_busy_i,
	output logic   tcp_op_rcv_rd_o,
	output logic   accept_o,
	output logic   syn_o,
	output logic   ack_o,
	output logic   fin_o,
	output logic   rst_o
);

	logic rd_allow;

	// Reads wait while a reply or a data segment is being started
	assign rd_allow = tcp_op_rcv_i & ~ctrl_cmd_start_i & ~tcp_wdat_start_i & ~trnsmt_busy_i;

	// One-cycle read strobe
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_op_rcv_rd_o <= 1'b0;
		else if (tcp_op_rcv_rd_o)
			tcp_op_rcv_rd_o <= 1'b0;
		else if (rd_allow)
			tcp_op_rcv_rd_o <= 1'b1;
	end

	// Flag events are valid only in the accepted cycle
	assign accept_o = tcp_op_rcv_i & tcp_op_rcv_rd_o;
	assign syn_o    = accept_o & tcp_flags_i[FLAG_SYN];
	assign ack_o    = accept_o & tcp_flags_i[FLAG_ACK];
	assign fin_o    = accept_o & tcp_flags_i[FLAG_FIN];
	assign rst_o    = accept_o & tcp_flags_i[FLAG_RST];

endmodule

//--- conn/tcp_conn_fsm.sv
module tcp_conn_fsm
	import tcp_pkg::*;
	import tcp_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        syn_i,
	input  logic        ack_i,
	input  logic        fin_i,
	input  logic        rst_i,
	input  port_t       tcp_source_port_i,
	output conn_state_t state_o,
	output port_t       peer_port_o,
	output logic        tcp_state_listen_o,
	output logic        tcp_state_estblsh_o
);

	conn_state_t state_q;
	conn_state_t state_d;
	port_t       peer_port_q;
	logic        open_req;
	logic        peer_rst;

	// Bare SYN opens a connection
	assign open_req = syn_i & ~ack_i;

	// RST counts only from the connected peer
	assign peer_rst = rst_i & (tcp_source_port_i == peer_port_q);

	// ------------------------------------------------------------
	// Next state
	// ------------------------------------------------------------
	always_comb
	begin
		state_d = state_q;
		case (state_q)
			LISTEN:
			begin
				if (open_req)
					state_d = SYN_RCVD;
			end
			SYN_RCVD:
			begin
				if (rst_i)
					state_d = LISTEN;
				else if (syn_i)
					state_d = CLOSED;
				else if (ack_i)
					state_d = ESTABLISHED;
			end
			ESTABLISHED:
			begin
				if (peer_rst)
					state_d = CLOSED;
				else if (fin_i)
					state_d = CLOSE_WAIT;
			end
			// Our FIN goes out from here, no wait for the application
			CLOSE_WAIT:
				state_d = LAST_ACK;
			LAST_ACK:
			begin
				if (ack_i | rst_i)
					state_d = CLOSED;
			end
			CLOSED:
				state_d = LISTEN;
			default:
				state_d = LISTEN;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state_q <= LISTEN;
		else
			state_q <= state_d;
	end

	// Peer port latched on the opening SYN
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			peer_port_q <= '0;
		else if (open_req && state_q == LISTEN)
			peer_port_q <= tcp_source_port_i;
	end

	assign state_o             = state_q;
	assign peer_port_o         = peer_port_q;
	assign tcp_state_listen_o  = (state_q == LISTEN);
	assign tcp_state_estblsh_o = (state_q == ESTABLISHED);

endmodule

//--- tx/tcp_seg_builder.sv
module tcp_seg_builder
	import tcp_pkg::*;
	import tcp_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  conn_state_t state_i,
	input  logic        accept_i,
	input  logic        syn_i,
	input  logic        ack_i,
	input  logic        fin_i,
	input  logic        rst_i,
	input  seq_num_t    tcp_seq_num_i,
	input  seq_num_t    tcp_ack_num_i,
	input  data_len_t   tcp_data_len_i,
	input  head_len_t   tcp_options_len_i,
	input  logic        tcp_wdat_start_i,
	input  logic        tcp_wdat_stop_i,
	input  logic        tx_lock_i,
	input  data_len_t   tx_dat_len_i,
	output logic        ctrl_cmd_start_o,
	output flags_t      tcp_flags_o,
	output seq_num_t    tcp_seq_num_o,
	output seq_num_t    tcp_ack_num_o,
	output head_len_t   tcp_head_len_o,
	output data_len_t   tcp_data_len_o
);

	logic     in_listen;
	logic     in_syn_rcvd;
	logic     in_estab;
	logic     in_closed;
	logic     synack_go;
	logic     lstn_rst_go;
	logic     data_ack_go;
	logic     fin_go;
	logic     clsd_rst_go;
	logic     in_order;
	seq_num_t seg_end;
	seq_num_t rcv_next_q;

	assign in_listen   = (state_i == LISTEN);
	assign in_syn_rcvd = (state_i == SYN_RCVD);
	assign in_estab    = (state_i == ESTABLISHED);
	assign in_closed   = (state_i == CLOSED);

	// Sequence number just past the received payload
	assign seg_end  = tcp_seq_num_i + seq_num_t'(tcp_data_len_i);
	assign in_order = (tcp_seq_num_i == rcv_next_q);

	// ------------------------------------------------------------
	// Reply triggers
	// ------------------------------------------------------------
	assign synack_go   = syn_i & ~ack_i & in_listen;
	assign lstn_rst_go = ack_i & in_listen;
	assign data_ack_go = ack_i & ~fin_i & (tcp_data_len_i != '0) & in_estab;
	assign fin_go      = (state_i == CLOSE_WAIT);
	assign clsd_rst_go = accept_i & ~rst_i & in_closed;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ctrl_cmd_start_o <= 1'b0;
		else if (ctrl_cmd_start_o)
			ctrl_cmd_start_o <= 1'b0;
		else if (synack_go | lstn_rst_go | data_ack_go | fin_go | clsd_rst_go)
			ctrl_cmd_start_o <= 1'b1;
	end

	// ------------------------------------------------------------
	// Header fields, loaded with the command pulse
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_flags_o <= '0;
		else if (lstn_rst_go)
			tcp_flags_o <= FLAGS_RST_ACK;
		else if (synack_go)
			tcp_flags_o <= FLAGS_SYN_ACK;
		else if (tcp_wdat_start_i && in_estab)
			tcp_flags_o <= FLAGS_PSH_ACK;
		else if (ack_i && !fin_i && in_estab)
			tcp_flags_o <= FLAGS_ACK;
		else if (fin_go)
			tcp_flags_o <= FLAGS_FIN_ACK;
		else if (clsd_rst_go)
			tcp_flags_o <= ack_i ? FLAGS_RST_ACK : FLAGS_RST;
	end

	// SYN takes one number, data advances by its length at the stop
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_seq_num_o <= INIT_SEQ_NUM;
		else if (lstn_rst_go)
			tcp_seq_num_o <= tcp_ack_num_i;
		else if (synack_go)
			tcp_seq_num_o <= INIT_SEQ_NUM;
		else if (ack_i && in_syn_rcvd)
			tcp_seq_num_o <= tcp_seq_num_o + 32'd1;
		else if (tcp_wdat_stop_i && tx_lock_i && in_estab)
			tcp_seq_num_o <= tcp_seq_num_o + seq_num_t'(tx_dat_len_i);
		else if (clsd_rst_go && ack_i)
			tcp_seq_num_o <= tcp_ack_num_i;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_ack_num_o <= '0;
		else if (lstn_rst_go)
			tcp_ack_num_o <= tcp_seq_num_i;
		else if (synack_go || (fin_i && in_estab))
			tcp_ack_num_o <= tcp_seq_num_i + 32'd1;
		else if (ack_i && in_estab && in_order)
			tcp_ack_num_o <= seg_end;
		else if (clsd_rst_go && !ack_i)
			tcp_ack_num_o <= seg_end;
	end

	// Next in-order receive number
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			rcv_next_q <= '0;
		else if (ack_i && (in_syn_rcvd || (in_estab && in_order)))
			rcv_next_q <= seg_end;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_head_len_o <= BASE_HEAD_LEN;
		else if (in_closed)
			tcp_head_len_o <= BASE_HEAD_LEN + tcp_options_len_i;
		else if (lstn_rst_go || in_estab)
			tcp_head_len_o <= BASE_HEAD_LEN;
	end

	// Payload length is nonzero only for PSH+ACK
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tcp_data_len_o <= '0;
		else if (in_listen || in_closed)
			tcp_data_len_o <= '0;
		else if (tcp_wdat_start_i && in_estab)
			tcp_data_len_o <= tx_dat_len_i;
		else if (data_ack_go || (fin_i && in_estab))
			tcp_data_len_o <= '0;
	end

endmodule

//--- tx/tcp_tx_gate.sv
module tcp_tx_gate
	import tcp_pkg::*;
	import tcp_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  conn_state_t state_i,
	input  logic        accept_i,
	input  logic        ack_i,
	input  logic        tcp_op_rcv_i,
	input  logic        ctrl_cmd_start_i,
	input  logic        trnsmt_busy_i,
	input  logic        tx_dat_avail_i,
	input  logic        tcp_wdat_stop_i,
	input  seq_num_t    tcp_ack_num_i,
	input  window_t     tcp_window_i,
	input  seq_num_t    seq_num_i,
	output logic        tcp_wdat_start_o,
	output logic        tx_lock_o
);

	pkt_cnt_t   pkt_cnt_q;
	tx_window_t window_q;
	logic       in_estab;
	logic       in_idle_state;
	logic       path_idle;
	logic       limits_ok;

	assign in_estab      = (state_i == ESTABLISHED);
	assign in_idle_state = (state_i == LISTEN) || (state_i == CLOSED);

	// Received segments and control replies go first
	assign path_idle = ~tcp_op_rcv_i & ~ctrl_cmd_start_i & ~trnsmt_busy_i;
	assign limits_ok = (pkt_cnt_q < MAX_UNACKED_PKTS) && (window_q > MIN_TX_WINDOW);

	// Lock sets on this edge, so the start lasts one cycle
	assign tcp_wdat_start_o = in_estab & path_idle & ~tx_lock_o & tx_dat_avail_i & limits_ok;

	// ------------------------------------------------------------
	// Transfer lock, held until the encoder ends the payload
	// ------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			tx_lock_o <= 1'b0;
		else if (state_i == CLOSED)
			tx_lock_o <= 1'b0;
		else if (tcp_wdat_stop_i && in_estab)
			tx_lock_o <= 1'b0;
		else if (tcp_wdat_start_o)
			tx_lock_o <= 1'b1;
	end

	// Any ACK frees the whole flight
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pkt_cnt_q <= '0;
		else if (in_idle_state || (ack_i && in_estab))
			pkt_cnt_q <= '0;
		else if (tcp_wdat_start_o)
			pkt_cnt_q <= pkt_cnt_q + 5'd1;
	end

	// Usable window, right edge of peer window minus our next seq
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			window_q <= '0;
		else if (accept_i && state_i == SYN_RCVD)
			window_q <= tx_window_t'(tcp_window_i);
		else if (accept_i && in_estab)
			window_q <= tcp_ack_num_i + tx_window_t'(tcp_window_i) - seq_num_i;
	end

endmodule

//--- design/tcp_ctrl_top.sv
module tcp_ctrl_top
	import tcp_pkg::*;
	import tcp_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,

	// Received segment
	input  logic      tcp_op_rcv_i,
	input  port_t     tcp_source_port_i,
	input  flags_t    tcp_flags_i,
	input  seq_num_t  tcp_seq_num_i,
	input  seq_num_t  tcp_ack_num_i,
	input  data_len_t tcp_data_len_i,
	input  window_t   tcp_window_i,
	input  head_len_t tcp_options_len_i,
	output logic      tcp_op_rcv_rd_o,

	// Outgoing data source and encoder
	input  logic      tx_dat_avail_i,
	input  data_len_t tx_dat_len_i,
	input  logic      tcp_wdat_stop_i,
	input  logic      trnsmt_busy_i,
	output logic      ctrl_cmd_start_o,
	output logic      tcp_wdat_start_o,

	// Header fields of the segment to send
	output port_t     tcp_source_port_o,
	output port_t     tcp_dest_port_o,
	output flags_t    tcp_flags_o,
	output seq_num_t  tcp_seq_num_o,
	output seq_num_t  tcp_ack_num_o,
	output head_len_t tcp_head_len_o,
	output data_len_t tcp_data_len_o,

	output logic      tcp_state_listen_o,
	output logic      tcp_state_estblsh_o
);

	logic        accept_ev;
	logic        syn_ev;
	logic        ack_ev;
	logic        fin_ev;
	logic        rst_ev;
	logic        tx_lock;
	conn_state_t conn_state;

	assign tcp_source_port_o = LOCAL_PORT;

	tcp_rx_intake u_tcp_rx_intake (
		.clk,
		.rst_n,
		.tcp_op_rcv_i,
		.tcp_flags_i,
		.ctrl_cmd_start_i (ctrl_cmd_start_o),
		.tcp_wdat_start_i (tcp_wdat_start_o),
		.trnsmt_busy_i,
		.tcp_op_rcv_rd_o,
		.accept_o         (accept_ev),
		.syn_o            (syn_ev),
		.ack_o            (ack_ev),
		.fin_o            (fin_ev),
		.rst_o            (rst_ev)
	);

	tcp_conn_fsm u_tcp_conn_fsm (
		.clk,
		.rst_n,
		.syn_i               (syn_ev),
		.ack_i               (ack_ev),
		.fin_i               (fin_ev),
		.rst_i               (rst_ev),
		.tcp_source_port_i,
		.state_o             (conn_state),
		.peer_port_o         (tcp_dest_port_o),
		.tcp_state_listen_o,
		.tcp_state_estblsh_o
	);

	tcp_seg_builder u_tcp_seg_builder (
		.clk,
		.rst_n,
		.state_i           (conn_state),
		.accept_i          (accept_ev),
		.syn_i             (syn_ev),
		.ack_i             (ack_ev),
		.fin_i             (fin_ev),
		.rst_i             (rst_ev),
		.tcp_seq_num_i,
		.tcp_ack_num_i,
		.tcp_data_len_i,
		.tcp_options_len_i,
		.tcp_wdat_start_i  (tcp_wdat_start_o),
		.tcp_wdat_stop_i,
		.tx_lock_i         (tx_lock),
		.tx_dat_len_i,
		.ctrl_cmd_start_o,
		.tcp_flags_o,
		.tcp_seq_num_o,
		.tcp_ack_num_o,
		.tcp_head_len_o,
		.tcp_data_len_o
	);

	tcp_tx_gate u_tcp_tx_gate (
		.clk,
		.rst_n,
		.state_i          (conn_state),
		.accept_i         (accept_ev),
		.ack_i            (ack_ev),
		.tcp_op_rcv_i,
		.ctrl_cmd_start_i (ctrl_cmd_start_o),
		.trnsmt_busy_i,
		.tx_dat_avail_i,
		.tcp_wdat_stop_i,
		.tcp_ack_num_i,
		.tcp_window_i,
		.seq_num_i        (tcp_seq_num_o),
		.tcp_wdat_start_o,
		.tx_lock_o        (tx_lock)
	);

endmodule

//--- test/tb_tcp_ctrl_assert.sv
module tb_tcp_ctrl_assert (
	input logic clk,
	input logic rst_n,
	input logic rd_strobe_i,
	input logic cmd_start_i,
	input logic wdat_start_i,
	input logic estblsh_i
);

	timeunit 1ns;
	timeprecision 1ps;

	// ------------------------------------------------------------
	// Single-cycle strobes
	// ------------------------------------------------------------
	rd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		rd_strobe_i |=> !rd_strobe_i)
		else $error("Read strobe held for more than one cycle");

	cmd_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_start_i |=> !cmd_start_i)
		else $error("Command pulse held for more than one cycle");

	wdat_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		wdat_start_i |=> !wdat_start_i)
		else $error("Data start held for more than one cycle");

	// Data only goes out on an open connection
	wdat_in_estab: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(wdat_start_i) |-> estblsh_i)
		else $error("Data start outside ESTABLISHED");

endmodule

//--- test/tb_tcp_ctrl.sv
module tb_tcp_ctrl
	import tcp_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          HALF_PERIOD  = 4;
	localparam int unsigned SEED         = 32'h83843c31;
	localparam int          NUM_ROWS     = 6;
	localparam int          PKT_LIMIT    = 16;
	localparam int          TX_BURSTS    = PKT_LIMIT + 1;
	localparam int          IDLE_CYCLES  = 10;
	localparam int          QUIET_CYCLES = 8;
	localparam int          LIMIT_WAIT   = 50;
	localparam int          ROW_BUDGET   = 200;
	localparam int          DATA_BUDGET  = TX_BURSTS * 10 + LIMIT_WAIT + ROW_BUDGET;
	localparam int          TIMEOUT_CYCLES = NUM_ROWS * ROW_BUDGET + DATA_BUDGET;
	localparam window_t     WIN_BYTES    = 16'd60000;
	localparam head_len_t   HLEN_BASE    = 4'd5;
	localparam head_len_t   OPT_WORDS    = 4'd3;

	// One received segment and the reply it should produce
	typedef struct packed {
		flags_t    flags;
		seq_num_t  seq;
		seq_num_t  ack;
		data_len_t len;
		window_t   win;
		port_t     port;
		bit        pulse;
		flags_t    exp_flags;
		seq_num_t  exp_seq;
		seq_num_t  exp_ack;
		bit        chk_ack;
		bit        chk_dport;
		bit        exp_listen;
		bit        exp_estab;
		head_len_t exp_hlen;
	} seg_row_t;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      tcp_op_rcv_i;
	port_t     tcp_source_port_i;
	flags_t    tcp_flags_i;
	seq_num_t  tcp_seq_num_i;
	seq_num_t  tcp_ack_num_i;
	data_len_t tcp_data_len_i;
	window_t   tcp_window_i;
	head_len_t tcp_options_len_i;
	logic      tx_dat_avail_i;
	data_len_t tx_dat_len_i;
	logic      tcp_wdat_stop_i;
	logic      trnsmt_busy_i;
	logic      tcp_op_rcv_rd_o;
	logic      ctrl_cmd_start_o;
	logic      tcp_wdat_start_o;
	port_t     tcp_source_port_o;
	port_t     tcp_dest_port_o;
	flags_t    tcp_flags_o;
	seq_num_t  tcp_seq_num_o;
	seq_num_t  tcp_ack_num_o;
	head_len_t tcp_head_len_o;
	data_len_t tcp_data_len_o;
	logic      tcp_state_listen_o;
	logic      tcp_state_estblsh_o;

	seg_row_t  rows [NUM_ROWS];
	string     row_name [NUM_ROWS];
	data_len_t tx_len [TX_BURSTS];
	port_t     peer_port;
	seq_num_t  peer_seq;
	seq_num_t  peer_next;
	data_len_t rx_len;
	seq_num_t  tx_end;
	int        start_count = 0;
	int        cycle_cnt = 0;

	tcp_ctrl_top u_tcp_ctrl_top (
		.clk                 (clk),
		.rst_n               (rst_n),
		.tcp_op_rcv_i        (tcp_op_rcv_i),
		.tcp_source_port_i   (tcp_source_port_i),
		.tcp_flags_i         (tcp_flags_i),
		.tcp_seq_num_i       (tcp_seq_num_i),
		.tcp_ack_num_i       (tcp_ack_num_i),
		.tcp_data_len_i      (tcp_data_len_i),
		.tcp_window_i        (tcp_window_i),
		.tcp_options_len_i   (tcp_options_len_i),
		.tcp_op_rcv_rd_o     (tcp_op_rcv_rd_o),
		.tx_dat_avail_i      (tx_dat_avail_i),
		.tx_dat_len_i        (tx_dat_len_i),
		.tcp_wdat_stop_i     (tcp_wdat_stop_i),
		.trnsmt_busy_i       (trnsmt_busy_i),
		.ctrl_cmd_start_o    (ctrl_cmd_start_o),
		.tcp_wdat_start_o    (tcp_wdat_start_o),
		.tcp_source_port_o   (tcp_source_port_o),
		.tcp_dest_port_o     (tcp_dest_port_o),
		.tcp_flags_o         (tcp_flags_o),
		.tcp_seq_num_o       (tcp_seq_num_o),
		.tcp_ack_num_o       (tcp_ack_num_o),
		.tcp_head_len_o      (tcp_head_len_o),
		.tcp_data_len_o      (tcp_data_len_o),
		.tcp_state_listen_o  (tcp_state_listen_o),
		.tcp_state_estblsh_o (tcp_state_estblsh_o)
	);

	bind tcp_ctrl_top tb_tcp_ctrl_assert u_tb_tcp_ctrl_assert (
		.clk          (clk),
		.rst_n        (rst_n),
		.rd_strobe_i  (tcp_op_rcv_rd_o),
		.cmd_start_i  (ctrl_cmd_start_o),
		.wdat_start_i (tcp_wdat_start_o),
		.estblsh_i    (tcp_state_estblsh_o)
	);

	always #HALF_PERIOD clk = ~clk;

	// Data starts counted where the strobe is settled
	always @(posedge clk)
	begin
		if (tcp_wdat_start_o)
			start_count <= start_count + 1;
	end

	always @(posedge clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the DUT stopped responding after %0d cycles", cycle_cnt);
			stop_run();
		end
	end

	// ------------------------------------------------------------
	// Compare tasks
	// ------------------------------------------------------------
	task automatic stop_run();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic compare_flags(input string name, input flags_t exp, input flags_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_seq(input string name, input seq_num_t exp, input seq_num_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_port(input string name, input port_t exp, input port_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_len(input string name, input data_len_t exp, input data_len_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_hlen(input string name, input head_len_t exp, input head_len_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic compare_bit(input string name, input bit exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %s: expected %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	// ------------------------------------------------------------
	// Stimulus table
	// ------------------------------------------------------------
	task automatic build_table();
		port_t    stray_port;
		seq_num_t stray_seq;
		seq_num_t stray_ack;
		peer_port  = port_t'($urandom);
		peer_seq   = $urandom;
		rx_len     = data_len_t'($urandom_range(1460, 1));
		stray_port = port_t'($urandom);
		stray_seq  = $urandom;
		stray_ack  = $urandom;
		peer_next  = peer_seq + 32'd1 + {16'h0, rx_len};
		// Our SYN takes one number, then each burst its length
		tx_end = 32'd1;
		for (int k = 0; k < TX_BURSTS; k++)
		begin
			tx_len[k] = data_len_t'($urandom_range(1460, 64));
			tx_end    = tx_end + {16'h0, tx_len[k]};
		end
		// flags, seq, ack, len, win, port, pulse,
		// exp flags, exp seq, exp ack, chk ack, chk dport, listen, estab, head len
		row_name[0] = "syn_open";
		rows[0] = '{6'h02, peer_seq, 32'd0, 16'd0, WIN_BYTES, peer_port, 1'b1,
			6'h12, 32'd0, peer_seq + 32'd1, 1'b1, 1'b1, 1'b0, 1'b0, HLEN_BASE};
		row_name[1] = "ack_open";
		rows[1] = '{6'h10, peer_seq + 32'd1, 32'd1, 16'd0, WIN_BYTES, peer_port, 1'b0,
			6'h00, 32'd0, 32'd0, 1'b0, 1'b0, 1'b0, 1'b1, HLEN_BASE};
		row_name[2] = "data_in";
		rows[2] = '{6'h10, peer_seq + 32'd1, 32'd1, rx_len, WIN_BYTES, peer_port, 1'b1,
			6'h10, 32'd1, peer_next, 1'b1, 1'b1, 1'b0, 1'b1, HLEN_BASE};
		row_name[3] = "fin_in";
		rows[3] = '{6'h11, peer_next, tx_end, 16'd0, WIN_BYTES, peer_port, 1'b1,
			6'h11, tx_end, peer_next + 32'd1, 1'b1, 1'b1, 1'b0, 1'b0, HLEN_BASE};
		// Passing through CLOSED picks up the options length
		row_name[4] = "last_ack";
		rows[4] = '{6'h10, peer_next + 32'd1, tx_end + 32'd1, 16'd0, WIN_BYTES, peer_port,
			1'b0, 6'h00, 32'd0, 32'd0, 1'b0, 1'b0, 1'b1, 1'b0, HLEN_BASE + OPT_WORDS};
		row_name[5] = "ack_in_listen";
		rows[5] = '{6'h10, stray_seq, stray_ack, 16'd0, WIN_BYTES, stray_port, 1'b1,
			6'h14, stray_ack, 32'd0, 1'b0, 1'b0, 1'b1, 1'b0, HLEN_BASE};
	endtask

	// Level handshake, dropped one edge after the accepted cycle
	task automatic send_segment(input flags_t f, input seq_num_t s, input seq_num_t a,
		input data_len_t l, input window_t w, input port_t p);
		tcp_flags_i       = f;
		tcp_seq_num_i     = s;
		tcp_ack_num_i     = a;
		tcp_data_len_i    = l;
		tcp_window_i      = w;
		tcp_source_port_i = p;
		tcp_op_rcv_i      = 1'b1;
		@(negedge clk);
		while (!tcp_op_rcv_rd_o)
			@(negedge clk);
		@(negedge clk);
		tcp_op_rcv_i = 1'b0;
	endtask

	task automatic apply_row(input int i);
		seg_row_t r;
		string    name;
		r    = rows[i];
		name = row_name[i];
		send_segment(r.flags, r.seq, r.ack, r.len, r.win, r.port);
		if (r.pulse)
		begin
			while (!ctrl_cmd_start_o)
				@(negedge clk);
			compare_flags({name, " flags"}, r.exp_flags, tcp_flags_o);
			compare_seq({name, " seq"}, r.exp_seq, tcp_seq_num_o);
			if (r.chk_ack)
				compare_seq({name, " ack"}, r.exp_ack, tcp_ack_num_o);
			if (r.chk_dport)
				compare_port({name, " dest port"}, r.port, tcp_dest_port_o);
			compare_port({name, " source port"}, 16'hF718, tcp_source_port_o);
		end
		else
		begin
			repeat (QUIET_CYCLES)
			begin
				if (ctrl_cmd_start_o)
				begin
					$display("Segment %s needs no reply but a command pulse came out", name);
					stop_run();
				end
				@(negedge clk);
			end
		end
		compare_bit({name, " listen"}, r.exp_listen, tcp_state_listen_o);
		compare_bit({name, " established"}, r.exp_estab, tcp_state_estblsh_o);
		compare_hlen({name, " header length"}, r.exp_hlen, tcp_head_len_o);
	endtask

	task automatic watch_idle();
		repeat (IDLE_CYCLES)
		begin
			compare_bit("idle listen", 1'b1, tcp_state_listen_o);
			compare_bit("idle established", 1'b0, tcp_state_estblsh_o);
			compare_bit("idle read strobe", 1'b0, tcp_op_rcv_rd_o);
			compare_bit("idle command pulse", 1'b0, ctrl_cmd_start_o);
			compare_bit("idle data start", 1'b0, tcp_wdat_start_o);
			@(negedge clk);
		end
	endtask

	// ------------------------------------------------------------
	// Outgoing data up to the packet limit and past it
	// ------------------------------------------------------------
	task automatic send_data();
		seq_num_t exp_seq;
		int       base;
		exp_seq        = 32'd1;
		tx_dat_len_i   = tx_len[0];
		tx_dat_avail_i = 1'b1;
		for (int k = 0; k < TX_BURSTS; k++)
		begin
			if (k == PKT_LIMIT)
			begin
				base = start_count;
				repeat (LIMIT_WAIT)
					@(negedge clk);
				if (start_count != base)
				begin
					$display("Data started with %0d packets unacknowledged", PKT_LIMIT);
					stop_run();
				end
				// Peer ACK frees the whole flight
				send_segment(6'h10, peer_next, exp_seq, 16'd0, WIN_BYTES, peer_port);
			end
			base = start_count;
			while (start_count == base)
				@(negedge clk);
			compare_flags($sformatf("burst %0d flags", k), 6'h18, tcp_flags_o);
			compare_len($sformatf("burst %0d length", k), tx_len[k], tcp_data_len_o);
			tcp_wdat_stop_i = 1'b1;
			if (k == TX_BURSTS - 1)
				tx_dat_avail_i = 1'b0;
			@(negedge clk);
			tcp_wdat_stop_i = 1'b0;
			exp_seq = exp_seq + {16'h0, tx_len[k]};
			compare_seq($sformatf("burst %0d seq after stop", k), exp_seq, tcp_seq_num_o);
			if (k < TX_BURSTS - 1)
				tx_dat_len_i = tx_len[k + 1];
		end
	endtask

	initial
	begin
		void'($urandom(SEED));
		rst_n             = 1'b0;
		tcp_op_rcv_i      = 1'b0;
		tcp_source_port_i = '0;
		tcp_flags_i       = '0;
		tcp_seq_num_i     = '0;
		tcp_ack_num_i     = '0;
		tcp_data_len_i    = '0;
		tcp_window_i      = '0;
		tcp_options_len_i = OPT_WORDS;
		tx_dat_avail_i    = 1'b0;
		tx_dat_len_i      = '0;
		tcp_wdat_stop_i   = 1'b0;
		trnsmt_busy_i     = 1'b0;
		build_table();
		repeat (3)
			@(negedge clk);
		rst_n = 1'b1;
		watch_idle();
		for (int i = 0; i < 3; i++)
			apply_row(i);
		send_data();
		for (int i = 3; i < NUM_ROWS; i++)
			apply_row(i);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- sources.f
common/tcp_pkg.sv
common/tcp_ctrl_pkg.sv
design/tcp_rx_intake.sv
conn/tcp_conn_fsm.sv
tx/tcp_seg_builder.sv
tx/tcp_tx_gate.sv
design/tcp_ctrl_top.sv
test/tb_tcp_ctrl_assert.sv
test/tb_tcp_ctrl.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_tcp_ctrl \
	-f sources.f \
	-o tb_tcp_ctrl

./obj_dir/tb_tcp_ctrl
